/* hdl/execPkg.sv */
`default_nettype none

package execPkg;

	localparam int regIdxWidth = 3; // eight architectural registers.
	localparam int dataWidthDefault = 16;

	typedef logic [dataWidthDefault-1:0] dataWord_t;
	typedef logic [regIdxWidth-1:0] regIdx_t;

	// ALU operation codes as the decode stage drives them.
	typedef enum logic [3:0] {
		aluAdd     = 4'h0,
		aluSub     = 4'h1, // second operand minus first.
		aluXor     = 4'h2,
		aluAndn    = 4'h3, // a and not b.
		aluRol     = 4'h4,
		aluSll     = 4'h5,
		aluRor     = 4'h6,
		aluSrl     = 4'h7,
		aluSeq     = 4'h8,
		aluSlt     = 4'h9,
		aluSle     = 4'hA,
		aluSco     = 4'hB, // carry out of a plus b.
		aluBtr     = 4'hC, // bit reverse of a.
		aluLbi     = 4'hD,
		aluPassA   = 4'hE,
		aluIllegal = 4'hF
	} aluOp_t;

	// Control bits that ride along past EX toward data memory and write-back.
	typedef struct packed {
		logic dmemEn;
		logic dmemWrite;
		logic dmemDump;
		logic memToReg;
	} memCtrl_t;

	localparam memCtrl_t memCtrlIdle = '0; // no memory access, result from ALU.

endpackage

`default_nettype wire

/* hdl/idExReg.sv */
`timescale 1ns/1ps
`default_nettype none

module idExReg
	import execPkg::*;
#(
	parameter int dataWidth = 16
) (
	input wire clk,
	input wire rstN,
	input wire dmemStall,
	input wire flush,

	input wire aluSrc2,
	input wire aluOp_t aluCtrl,
	input wire writeDataSel,
	input wire regWrite,
	input wire memCtrl_t memCtrl,
	input wire haltN,
	input wire errIn,
	input wire regIdx_t rs,
	input wire regIdx_t rt,
	input wire regIdx_t writeRegSel,
	input wire [dataWidth-1:0] readData1,
	input wire [dataWidth-1:0] readData2,
	input wire [dataWidth-1:0] immExt,
	input wire [dataWidth-1:0] pcAdd2,

	output logic idExAluSrc2,
	output aluOp_t idExAluCtrl,
	output logic idExWriteDataSel,
	output logic idExRegWrite,
	output memCtrl_t idExMemCtrl,
	output logic idExHaltN,
	output logic idExErr,
	output regIdx_t idExRs,
	output regIdx_t idExRt,
	output regIdx_t idExDest,
	output logic [dataWidth-1:0] idExData1,
	output logic [dataWidth-1:0] idExData2,
	output logic [dataWidth-1:0] idExImm,
	output logic [dataWidth-1:0] idExPcAdd2
);

	logic regWriteQ;
	memCtrl_t memCtrlQ;
	logic haltNQ;
	logic errQ;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			idExAluSrc2 <= 1'b0;
			idExAluCtrl <= aluAdd;
			idExWriteDataSel <= 1'b0;
			regWriteQ <= 1'b0;
			memCtrlQ <= memCtrlIdle;
			haltNQ <= 1'b1; // come out of reset running.
			errQ <= 1'b0;
		end else if (!dmemStall) begin
			idExAluSrc2 <= aluSrc2;
			idExAluCtrl <= aluCtrl;
			idExWriteDataSel <= writeDataSel;
			regWriteQ <= regWrite;
			memCtrlQ <= memCtrl;
			haltNQ <= haltN;
			errQ <= errIn;
		end
	end

	always_ff @(posedge clk) begin
		if (!dmemStall) begin
			idExRs <= rs;
			idExRt <= rt;
			idExDest <= writeRegSel;
			idExData1 <= readData1;
			idExData2 <= readData2;
			idExImm <= immExt;
			idExPcAdd2 <= pcAdd2;
		end
	end

	// A flushed slot leaves the stored fields alone and only masks what it presents.
	assign idExRegWrite = regWriteQ & ~flush;
	assign idExMemCtrl = flush ? memCtrlIdle : memCtrlQ;
	assign idExHaltN = haltNQ | flush;
	assign idExErr = errQ & ~flush;

endmodule

`default_nettype wire

/* hdl/forwardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwardUnit
	import execPkg::*;
#(
	parameter int dataWidth = 16
) (
	input wire regIdx_t idExRs,
	input wire regIdx_t idExRt,
	input wire [dataWidth-1:0] idExData1,
	input wire [dataWidth-1:0] idExData2,

	input wire regIdx_t exMemDest,
	input wire exMemRegWrite,
	input wire exMemMemToReg,
	input wire [dataWidth-1:0] exMemResult,

	input wire wbRegWrite,
	input wire regIdx_t wbDest,
	input wire [dataWidth-1:0] wbData,

	output logic [dataWidth-1:0] opA,
	output logic [dataWidth-1:0] opB
);

	logic exMemFwdEn;

	// a load in EX/MEM has no data yet and decode keeps such pairs apart.
	assign exMemFwdEn = exMemRegWrite & ~exMemMemToReg;

	function automatic logic [dataWidth-1:0] pickOperand(
		input regIdx_t src,
		input logic [dataWidth-1:0] rfData
	);
		if (exMemFwdEn && (exMemDest == src))
			return exMemResult; // the younger producer wins.
		else if (wbRegWrite && (wbDest == src))
			return wbData;
		else
			return rfData;
	endfunction

	always_comb begin
		opA = pickOperand(idExRs, idExData1);
		opB = pickOperand(idExRt, idExData2);
	end

endmodule

`default_nettype wire

/* hdl/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit
	import execPkg::*;
#(
	parameter int dataWidth = 16
) (
	input wire [dataWidth-1:0] opA,
	input wire [dataWidth-1:0] opB,
	input wire [dataWidth-1:0] imm,
	input wire [dataWidth-1:0] pcAdd2,
	input wire aluSrc2,
	input wire aluOp_t aluCtrl,
	input wire writeDataSel,

	output logic [dataWidth-1:0] result,
	output logic illegalOp
);

	localparam int shAmtWidth = $clog2(dataWidth);

	logic [dataWidth-1:0] srcB;
	logic [shAmtWidth-1:0] shAmt;
	logic [dataWidth:0] addFull;
	logic [2*dataWidth-1:0] rotLeft;
	logic [2*dataWidth-1:0] rotRight;
	logic [dataWidth-1:0] reversed;
	logic [dataWidth-1:0] rawResult;

	assign srcB = aluSrc2 ? imm : opB;
	assign shAmt = srcB[shAmtWidth-1:0];
	assign addFull = {1'b0, opA} + {1'b0, srcB}; // top bit is the sco carry.

	// rotating a doubled copy keeps the bits that fall off one end.
	assign rotLeft = {opA, opA} << shAmt;
	assign rotRight = {opA, opA} >> shAmt;

	always_comb begin
		for (int i = 0; i < dataWidth; i++) begin
			reversed[i] = opA[dataWidth-1-i];
		end
	end

	always_comb begin
		rawResult = '0;
		case (aluCtrl)
			aluAdd:   rawResult = addFull[dataWidth-1:0];
			aluSub:   rawResult = srcB - opA;
			aluXor:   rawResult = opA ^ srcB;
			aluAndn:  rawResult = opA & ~srcB;
			aluRol:   rawResult = rotLeft[2*dataWidth-1 -: dataWidth];
			aluSll:   rawResult = opA << shAmt;
			aluRor:   rawResult = rotRight[dataWidth-1:0];
			aluSrl:   rawResult = opA >> shAmt;
			aluSeq:   rawResult = dataWidth'(opA == srcB);
			aluSlt:   rawResult = dataWidth'($signed(opA) < $signed(srcB));
			aluSle:   rawResult = dataWidth'($signed(opA) <= $signed(srcB));
			aluSco:   rawResult = dataWidth'(addFull[dataWidth]);
			aluBtr:   rawResult = reversed;
			aluLbi:   rawResult = srcB;
			aluPassA: rawResult = opA;
			default:  rawResult = '0;
		endcase
	end

	assign illegalOp = (aluCtrl == aluIllegal);

	// Link instructions write the return address instead of the ALU value.
	assign result = writeDataSel ? pcAdd2 : rawResult;

endmodule

`default_nettype wire

/* hdl/exMemReg.sv */
`timescale 1ns/1ps
`default_nettype none

module exMemReg
	import execPkg::*;
#(
	parameter int dataWidth = 16
) (
	input wire clk,
	input wire rstN,
	input wire dmemStall,

	input wire [dataWidth-1:0] result,
	input wire [dataWidth-1:0] storeData,
	input wire regIdx_t dest,
	input wire regWrite,
	input wire memCtrl_t memCtrl,
	input wire haltN,
	input wire errIn,
	input wire illegalOp,

	output logic [dataWidth-1:0] exResult,
	output logic [dataWidth-1:0] exStoreData,
	output regIdx_t exDest,
	output logic exRegWrite,
	output memCtrl_t exMemCtrl,
	output logic exHaltN,
	output logic exErr
);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exRegWrite <= 1'b0;
			exMemCtrl <= memCtrlIdle;
			exHaltN <= 1'b1;
			exErr <= 1'b0;
		end else if (!dmemStall) begin
			exRegWrite <= regWrite;
			exMemCtrl <= memCtrl;
			exHaltN <= haltN;
			exErr <= errIn | illegalOp; // a decode error and a bad opcode raise the same flag.
		end
	end

	always_ff @(posedge clk) begin
		if (!dmemStall) begin
			exResult <= result;
			exStoreData <= storeData; // rt after forwarding.
			exDest <= dest;
		end
	end

endmodule

`default_nettype wire

/* hdl/execSlice.sv */
`timescale 1ns/1ps
`default_nettype none

module execSlice
	import execPkg::*;
#(
	parameter int dataWidth = $bits(dataWord_t)
) (
	input wire clk,
	input wire rstN,
	input wire dmemStall,
	input wire flush,

	input wire aluSrc2,
	input wire aluOp_t aluCtrl,
	input wire writeDataSel,
	input wire regWrite,
	input wire memCtrl_t memCtrl,
	input wire haltN,
	input wire errIn,
	input wire regIdx_t rs,
	input wire regIdx_t rt,
	input wire regIdx_t writeRegSel,
	input wire [dataWidth-1:0] readData1,
	input wire [dataWidth-1:0] readData2,
	input wire [dataWidth-1:0] immExt,
	input wire [dataWidth-1:0] pcAdd2,

	input wire wbRegWrite,
	input wire regIdx_t wbDest,
	input wire [dataWidth-1:0] wbData,

	output logic [dataWidth-1:0] exResult,
	output logic [dataWidth-1:0] exStoreData,
	output regIdx_t exDest,
	output logic exRegWrite,
	output memCtrl_t exMemCtrl,
	output logic exHaltN,
	output logic exErr
);

	logic idExAluSrc2;
	aluOp_t idExAluCtrl;
	logic idExWriteDataSel;
	logic idExRegWrite;
	memCtrl_t idExMemCtrl;
	logic idExHaltN;
	logic idExErr;
	regIdx_t idExRs;
	regIdx_t idExRt;
	regIdx_t idExDest;
	logic [dataWidth-1:0] idExData1;
	logic [dataWidth-1:0] idExData2;
	logic [dataWidth-1:0] idExImm;
	logic [dataWidth-1:0] idExPcAdd2;

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluResult;
	logic illegalOp;

	idExReg #(.dataWidth(dataWidth)) idExStage (
		.clk, .rstN, .dmemStall, .flush,
		.aluSrc2, .aluCtrl, .writeDataSel, .regWrite, .memCtrl, .haltN, .errIn,
		.rs, .rt, .writeRegSel, .readData1, .readData2, .immExt, .pcAdd2,
		.idExAluSrc2, .idExAluCtrl, .idExWriteDataSel, .idExRegWrite,
		.idExMemCtrl, .idExHaltN, .idExErr, .idExRs, .idExRt, .idExDest,
		.idExData1, .idExData2, .idExImm, .idExPcAdd2
	);

	// EX/MEM feeds back its own registered outputs as the younger producer.
	forwardUnit #(.dataWidth(dataWidth)) fwd (
		.idExRs, .idExRt, .idExData1, .idExData2,
		.exMemDest(exDest),
		.exMemRegWrite(exRegWrite),
		.exMemMemToReg(exMemCtrl.memToReg),
		.exMemResult(exResult),
		.wbRegWrite, .wbDest, .wbData,
		.opA, .opB
	);

	aluUnit #(.dataWidth(dataWidth)) alu (
		.opA, .opB,
		.imm(idExImm),
		.pcAdd2(idExPcAdd2),
		.aluSrc2(idExAluSrc2),
		.aluCtrl(idExAluCtrl),
		.writeDataSel(idExWriteDataSel),
		.result(aluResult),
		.illegalOp
	);

	exMemReg #(.dataWidth(dataWidth)) exMemStage (
		.clk, .rstN, .dmemStall,
		.result(aluResult),
		.storeData(opB),
		.dest(idExDest),
		.regWrite(idExRegWrite),
		.memCtrl(idExMemCtrl),
		.haltN(idExHaltN),
		.errIn(idExErr),
		.illegalOp,
		.exResult, .exStoreData, .exDest, .exRegWrite, .exMemCtrl, .exHaltN, .exErr
	);

endmodule

`default_nettype wire

/* test/execRefModel.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

typedef struct packed {
	logic aluSrc2, writeDataSel, regWrite, haltN, errIn;
	aluOp_t aluCtrl;
	memCtrl_t memCtrl;
	regIdx_t rs, rt, dest;
	dataWord_t data1, data2, imm, pcAdd2;
} instr_t;

typedef struct packed {
	logic dataValid, regWrite, haltN, err; // dataValid is low for the bubble reset leaves.
	dataWord_t result, storeData;
	regIdx_t dest;
	memCtrl_t memCtrl;
} exMemEntry_t;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

function automatic exMemEntry_t idleEntry();
	exMemEntry_t e;
	e = '0;
	e.haltN = 1'b1;
	return e;
endfunction

function automatic dataWord_t refAlu(input aluOp_t op, input dataWord_t a, input dataWord_t b);
	int s;
	int i;
	dataWord_t r;
	s = int'(b[3:0]); // shift and rotate amounts come from the low four bits.
	r = '0;
	case (op)
		aluAdd:   r = a + b;
		aluSub:   r = b - a;
		aluXor:   r = a ^ b;
		aluAndn:  r = a & ~b;
		aluRol:   r = (a << s) | (a >> (16 - s));
		aluSll:   r = a << s;
		aluRor:   r = (a >> s) | (a << (16 - s));
		aluSrl:   r = a >> s;
		aluSeq:   r[0] = (a == b);
		aluSlt:   r[0] = ($signed(a) < $signed(b));
		aluSle:   r[0] = ($signed(a) <= $signed(b));
		aluSco:   r[0] = 1'(({1'b0, a} + {1'b0, b}) >> 16);
		aluBtr:   for (i = 0; i < 16; i++) r[i] = a[15 - i];
		aluLbi:   r = b;
		aluPassA: r = a;
		default:  r = '0;
	endcase
	return r;
endfunction

function automatic dataWord_t resolveOperand(input regIdx_t src, input dataWord_t rfData,
	input exMemEntry_t prev, input logic wbRw, input regIdx_t wbDst, input dataWord_t wbVal);
	if (prev.regWrite && !prev.memCtrl.memToReg && prev.dest == src)
		return prev.result;
	if (wbRw && wbDst == src)
		return wbVal;
	return rfData;
endfunction

function automatic exMemEntry_t refExecute(input instr_t ins, input exMemEntry_t prev,
	input logic flushed, input logic wbRw, input regIdx_t wbDst, input dataWord_t wbVal);
	exMemEntry_t e;
	dataWord_t a;
	dataWord_t b;
	a = resolveOperand(ins.rs, ins.data1, prev, wbRw, wbDst, wbVal);
	b = resolveOperand(ins.rt, ins.data2, prev, wbRw, wbDst, wbVal);
	e.dataValid = 1'b1;
	e.result = ins.writeDataSel ? ins.pcAdd2 : refAlu(ins.aluCtrl, a, ins.aluSrc2 ? ins.imm : b);
	e.storeData = b; // stores take rt, never the immediate.
	e.dest = ins.dest;
	e.regWrite = ins.regWrite && !flushed;
	e.memCtrl = flushed ? memCtrlIdle : ins.memCtrl;
	e.haltN = ins.haltN || flushed;
	e.err = (ins.errIn && !flushed) || ins.aluCtrl == aluIllegal; // a bad opcode flags even a bubble.
	return e;
endfunction

`endif

/* test/execSliceTb.sv */
`timescale 1ns/1ps
`default_nettype none

module execSliceTb
	import execPkg::*;
();

`include "execRefModel.svh"

	localparam int numCycles = 600;
	localparam int drainLimit = 20;

	logic clk, rstN, dmemStall, flush;
	logic aluSrc2, writeDataSel, regWrite, haltN, errIn, wbRegWrite;
	aluOp_t aluCtrl;
	memCtrl_t memCtrl, exMemCtrl;
	regIdx_t rs, rt, writeRegSel, wbDest, exDest;
	dataWord_t readData1, readData2, immExt, pcAdd2, wbData, exResult, exStoreData;
	logic exRegWrite, exHaltN, exErr;

	logic [31:0] rng;
	instr_t inEx; // the instruction ID/EX holds now.
	logic inExValid;
	exMemEntry_t memShadow; // what EX/MEM holds while inEx sits in ID/EX.
	exMemEntry_t expQ[$];
	int checks = 0, dataErrors = 0, destErrors = 0, ctrlErrors = 0, seqErrors = 0;
	logic timedOut;

	execSlice #(.dataWidth($bits(dataWord_t))) execSlice_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic instr_t drawInstr(input logic allowBad);
		instr_t ins;
		logic [31:0] r;
		ins.aluCtrl = aluOp_t'(4'(nextRand() % 15));
		r = nextRand();
		if (allowBad && r[3:0] == 4'd0)
			ins.aluCtrl = aluIllegal;
		ins.errIn = allowBad && r[7:4] == 4'd0;
		ins.aluSrc2 = r[8];
		ins.writeDataSel = r[11:9] == 3'd0; // links are rare.
		ins.regWrite = r[13:12] != 2'd0;
		ins.memCtrl = r[17:14];
		ins.haltN = r[21:18] != 4'd0;
		ins.rs = r[22] ? inEx.dest : r[25:23]; // lean on the older result to force forwarding.
		ins.rt = r[26] ? inEx.dest : r[29:27];
		ins.dest = regIdx_t'(nextRand());
		ins.data1 = dataWord_t'(nextRand());
		ins.data2 = dataWord_t'(nextRand());
		ins.imm = dataWord_t'(nextRand());
		ins.pcAdd2 = dataWord_t'(nextRand());
		return ins;
	endfunction

	task automatic applyInstr(input instr_t ins);
		aluSrc2 = ins.aluSrc2;
		aluCtrl = ins.aluCtrl;
		writeDataSel = ins.writeDataSel;
		regWrite = ins.regWrite;
		memCtrl = ins.memCtrl;
		haltN = ins.haltN;
		errIn = ins.errIn;
		rs = ins.rs;
		rt = ins.rt;
		writeRegSel = ins.dest;
		readData1 = ins.data1;
		readData2 = ins.data2;
		immExt = ins.imm;
		pcAdd2 = ins.pcAdd2;
	endtask

	task automatic checkData(input string what, input dataWord_t got, input dataWord_t exp);
		checks++;
		if (got !== exp) begin
			dataErrors++;
			$display("[ERROR] at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkDest(input regIdx_t got, input regIdx_t exp);
		checks++;
		if (got !== exp) begin
			destErrors++;
			$display("[ERROR] at %0d ns: exDest is %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic checkCtrl(input memCtrl_t gotMem, input logic gotRw, input logic gotHaltN,
		input logic gotErr, input exMemEntry_t exp);
		checks++;
		if ({gotMem, gotRw, gotHaltN, gotErr} !==
			{exp.memCtrl, exp.regWrite, exp.haltN, exp.err}) begin
			ctrlErrors++;
			$display("[ERROR] at %0d ns: mem/rw/haltN/err is %b/%b/%b/%b, expected %b/%b/%b/%b",
				$time, gotMem, gotRw, gotHaltN, gotErr,
				exp.memCtrl, exp.regWrite, exp.haltN, exp.err);
		end
	endtask

	// EX/MEM is checked every cycle, so a stalled edge must show the last result again.
	initial begin
		exMemEntry_t held;
		logic moved;
		held = idleEntry();
		forever begin
			@(posedge clk);
			moved = rstN && !dmemStall;
			#10;
			if (moved && expQ.size() == 0) begin
				seqErrors++;
				$display("EX/MEM advanced at %0d ns with no instruction expected", $time);
			end else if (moved) begin
				held = expQ.pop_front();
			end
			checkCtrl(exMemCtrl, exRegWrite, exHaltN, exErr, held);
			if (held.dataValid) begin
				checkData("exResult", exResult, held.result);
				checkData("exStoreData", exStoreData, held.storeData);
				checkDest(exDest, held.dest);
			end
		end
	end

	initial begin
		exMemEntry_t exp;
		logic [31:0] r;
		int waited;
		rng = 32'd53523;
		rstN = 1'b0;
		dmemStall = 1'b0;
		flush = 1'b0;
		wbRegWrite = 1'b0;
		wbDest = '0;
		wbData = '0;
		inEx = '0;
		inExValid = 1'b0;
		memShadow = idleEntry();
		applyInstr('0);
		repeat (5) @(negedge clk);
		rstN = 1'b1;
		for (int cyc = 0; cyc < numCycles; cyc++) begin
			r = nextRand();
			dmemStall = (cyc >= 200) && (dmemStall ? r[0] : r[3:1] == 3'd0); // bursts.
			flush = (cyc >= 100) && r[6:4] == 3'd0;
			wbRegWrite = r[7];
			wbDest = r[8] ? inEx.rs : (r[9] ? inEx.rt : r[12:10]);
			wbData = dataWord_t'(nextRand());
			if (dmemStall) begin
				applyInstr(drawInstr(1'b1)); // ID/EX has to ignore this.
			end else begin
				exp = inExValid ? refExecute(inEx, memShadow, flush, wbRegWrite, wbDest, wbData)
					: idleEntry();
				expQ.push_back(exp);
				memShadow = exp;
				inEx = drawInstr(cyc >= 300);
				inExValid = 1'b1;
				applyInstr(inEx);
			end
			@(negedge clk);
		end
		// carry the last issued instruction on into EX/MEM.
		dmemStall = 1'b0;
		exp = refExecute(inEx, memShadow, flush, wbRegWrite, wbDest, wbData);
		expQ.push_back(exp);
		waited = 0;
		while (expQ.size() != 0 && waited < drainLimit) begin
			@(negedge clk);
			waited++;
		end
		timedOut = expQ.size() != 0;
		if (timedOut)
			$display("timed out with %0d results never reaching EX/MEM", expQ.size());
		$display("checks %0d, errors: data %0d, dest %0d, control %0d, order %0d",
			checks, dataErrors, destErrors, ctrlErrors, seqErrors);
		if (!timedOut && checks > 0 && dataErrors + destErrors + ctrlErrors + seqErrors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* execSlice.f */
+incdir+test
hdl/execPkg.sv
hdl/idExReg.sv
hdl/forwardUnit.sv
hdl/aluUnit.sv
hdl/exMemReg.sv
hdl/execSlice.sv
test/execSliceTb.sv

/* Makefile */
SIM       := verilator
SIMFLAGS  := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := execSliceTb
RTL_TOP   := execSlice
FILELIST  := execSlice.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
